//--- design/renamePkg.sv
// Rename commit and recovery package.
// Widths, active list entry and release lane types shared by the
// active list, the free list and the rename committer.

`default_nettype none

package renamePkg;

    // Commit and release lanes per cycle.
    localparam int commitWidth = 2;

    // Active list entries.
    localparam int activeListDepth = 16;

    // Physical and architectural register file sizes.
    localparam int physRegNum = 32;
    localparam int logRegNum = 8;

    // Physical register number.
    typedef logic [4:0] PhysReg;

    // Position inside the active list.
    typedef logic [3:0] AlIndex;

    // Active list occupancy, 0 to 16.
    typedef logic [4:0] AlCount;

    // Lane count, 0 to 2.
    typedef logic [1:0] LaneCount;

    // Free list occupancy, 0 to 32.
    typedef logic [5:0] FreeCount;

    // One dispatched op as kept in the active list.
    typedef struct packed {
        logic   writeReg;
        PhysReg physDst;
        PhysReg physPrevDst;
    } AlEntry;

    // One register handed back to the free list.
    typedef struct packed {
        logic   valid;
        PhysReg physReg;
    } ReleaseLane;

    // Committer phases.
    typedef enum logic [1:0] {
        phaseCommit   = 2'd0,
        phaseRecover0 = 2'd1,
        phaseRecover1 = 2'd2
    } RecoveryPhase;

endpackage

`default_nettype wire

//--- design/activeList.sv
// Active list.
// Circular queue of dispatched ops in program order. One push per
// cycle at the tail, commit pops at the head, recovery pops at the tail.

`default_nettype none
`timescale 1ns/100ps

module activeList (
    input  logic                                               clk,
    input  logic                                               rstN,
    input  logic                                               pushValid,
    input  renamePkg::AlEntry                                  pushEntry,
    output renamePkg::AlIndex                                  pushIndex,
    output logic                                               full,
    input  renamePkg::LaneCount                                popHeadNum,
    input  renamePkg::LaneCount                                popTailNum,
    // Oldest squashed position, held until the recovery ends.
    input  renamePkg::AlIndex                                  flushIndex,
    output renamePkg::AlEntry [renamePkg::commitWidth-1:0]     headEntries,
    output renamePkg::AlEntry [renamePkg::commitWidth-1:0]     tailEntries,
    output renamePkg::AlCount                                  recoveryEntryNum,
    output renamePkg::AlCount                                  count
);
    import renamePkg::*;

    AlEntry entries [activeListDepth];

    AlIndex head;
    AlIndex tail;
    AlCount entryCount;

    AlIndex flushDistance;

    // Entry storage, written only at the tail on a push.
    always_ff @(posedge clk) begin
        if (pushValid) begin
            entries[tail] <= pushEntry;
        end
    end

    // Pointers and occupancy.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            head       <= '0;
            tail       <= '0;
            entryCount <= '0;
        end else begin
            head       <= head + AlIndex'(popHeadNum);
            tail       <= tail + AlIndex'(pushValid) - AlIndex'(popTailNum);
            entryCount <= entryCount + AlCount'(pushValid)
                          - AlCount'(popHeadNum) - AlCount'(popTailNum);
        end
    end

    // Two oldest entries from the head, two youngest from the tail.
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            headEntries[i] = entries[head + AlIndex'(i)];
            tailEntries[i] = entries[tail - AlIndex'(i + 1)];
        end
    end

    // Squashed ops sit between flushIndex and the tail.
    // A full list with flushIndex at the tail squashes every entry.
    assign flushDistance = tail - flushIndex;

    always_comb begin
        if (full && flushDistance == '0) begin
            recoveryEntryNum = AlCount'(activeListDepth);
        end else begin
            recoveryEntryNum = AlCount'(flushDistance);
        end
    end

    assign full      = (entryCount == AlCount'(activeListDepth));
    assign pushIndex = tail;
    assign count     = entryCount;

endmodule

`default_nettype wire

//--- design/renameCommitter.sv
// Rename committer.
// Frees previous destinations of committing ops, and on recovery walks
// the active list back from the tail to free squashed destinations.
// Released registers leave through one register stage.

`default_nettype none
`timescale 1ns/100ps

module renameCommitter (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic                                                commit,
    input  renamePkg::LaneCount                                 commitNum,
    input  logic                                                recover,
    input  renamePkg::AlEntry [renamePkg::commitWidth-1:0]      headEntries,
    input  renamePkg::AlEntry [renamePkg::commitWidth-1:0]      tailEntries,
    input  renamePkg::AlCount                                   recoveryEntryNum,
    output renamePkg::LaneCount                                 popHeadNum,
    output renamePkg::LaneCount                                 popTailNum,
    output renamePkg::ReleaseLane [renamePkg::commitWidth-1:0]  releaseLanes,
    output renamePkg::LaneCount                                 flushNum,
    output logic                                                inRecovery
);
    import renamePkg::*;

    RecoveryPhase phase;
    RecoveryPhase nextPhase;

    // Squashed ops still to be popped from the tail.
    AlCount recoveryCount;
    AlCount nextRecoveryCount;

    ReleaseLane [commitWidth-1:0] laneReg;
    ReleaseLane [commitWidth-1:0] nextLanes;

    LaneCount releaseNum;

    // Phase and remaining count.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase         <= phaseCommit;
            recoveryCount <= '0;
        end else begin
            phase         <= nextPhase;
            recoveryCount <= nextRecoveryCount;
        end
    end

    // Release register stage.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            laneReg <= '0;
        end else begin
            laneReg <= nextLanes;
        end
    end

    // Tail pops this cycle, at most one lane group.
    always_comb begin
        if (recoveryCount > AlCount'(commitWidth)) begin
            releaseNum = LaneCount'(commitWidth);
        end else begin
            releaseNum = LaneCount'(recoveryCount);
        end
    end

    // Phase sequencing.
    always_comb begin
        nextPhase         = phase;
        nextRecoveryCount = recoveryCount;
        case (phase)
            phaseRecover0: begin
                // The tail has settled, so take the squash count now.
                nextPhase         = phaseRecover1;
                nextRecoveryCount = recoveryEntryNum;
            end
            phaseRecover1: begin
                if (recoveryCount == '0) begin
                    nextPhase = phaseCommit;
                end
                nextRecoveryCount = recoveryCount - AlCount'(releaseNum);
            end
            default: begin
                nextPhase = phaseCommit;
            end
        endcase
        if (recover) begin
            nextPhase         = phaseRecover0;
            nextRecoveryCount = '0;
        end
    end

    // Pops and release lanes.
    always_comb begin
        popHeadNum = '0;
        popTailNum = '0;
        flushNum   = '0;
        nextLanes  = '0;
        case (phase)
            phaseCommit: begin
                if (commit) begin
                    popHeadNum = commitNum;
                end
                for (int i = 0; i < commitWidth; i++) begin
                    nextLanes[i].valid   = commit && (LaneCount'(i) < commitNum)
                                           && headEntries[i].writeReg;
                    nextLanes[i].physReg = headEntries[i].physPrevDst;
                end
            end
            phaseRecover1: begin
                popTailNum = releaseNum;
                flushNum   = releaseNum;
                // Youngest squashed op goes out on lane 0.
                for (int i = 0; i < commitWidth; i++) begin
                    nextLanes[i].valid   = (LaneCount'(i) < releaseNum)
                                           && tailEntries[i].writeReg;
                    nextLanes[i].physReg = tailEntries[i].physDst;
                end
            end
            default: begin
                nextLanes = '0;
            end
        endcase
    end

    assign releaseLanes = laneReg;
    assign inRecovery   = (phase != phaseCommit);

endmodule

`default_nettype wire

//--- design/freeList.sv
// Physical register free list.
// Circular queue of free register numbers. The head is handed out at
// dispatch and up to two released registers are appended per cycle.

`default_nettype none
`timescale 1ns/100ps

module freeList (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic                                                allocate,
    output renamePkg::PhysReg                                   allocReg,
    output logic                                                empty,
    input  renamePkg::ReleaseLane [renamePkg::commitWidth-1:0]  releaseLanes,
    output renamePkg::FreeCount                                 count
);
    import renamePkg::*;

    PhysReg freeRegs [physRegNum];

    // Queue positions share the register number width.
    PhysReg head;
    PhysReg tail;
    FreeCount freeCount;

    // Number of valid release lanes this cycle.
    LaneCount releaseNum;

    // Second release lands behind the first only if the first is valid.
    PhysReg secondSlot;

    always_comb begin
        releaseNum = '0;
        for (int i = 0; i < commitWidth; i++) begin
            releaseNum = releaseNum + LaneCount'(releaseLanes[i].valid);
        end
    end

    assign secondSlot = tail + PhysReg'(releaseLanes[0].valid);

    // Storage. Reset loads the registers not mapped at start, in order.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < physRegNum; i++) begin
                if (i < physRegNum - logRegNum) begin
                    freeRegs[i] <= PhysReg'(i + logRegNum);
                end else begin
                    freeRegs[i] <= '0;
                end
            end
        end else begin
            if (releaseLanes[0].valid) begin
                freeRegs[tail] <= releaseLanes[0].physReg;
            end
            if (releaseLanes[1].valid) begin
                freeRegs[secondSlot] <= releaseLanes[1].physReg;
            end
        end
    end

    // Pointers and occupancy.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            head      <= '0;
            tail      <= PhysReg'(physRegNum - logRegNum);
            freeCount <= FreeCount'(physRegNum - logRegNum);
        end else begin
            head      <= head + PhysReg'(allocate);
            tail      <= tail + PhysReg'(releaseNum);
            freeCount <= freeCount - FreeCount'(allocate) + FreeCount'(releaseNum);
        end
    end

    assign allocReg = freeRegs[head];
    assign empty    = (freeCount == '0);
    assign count    = freeCount;

endmodule

`default_nettype wire

//--- design/renameUnit.sv
// Rename commit and recovery unit.
// Ties the active list, the free list and the rename committer
// together and gates dispatch on list space and recovery.

`default_nettype none
`timescale 1ns/100ps

module renameUnit (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic                                                dispatchValid,
    input  logic                                                dispatchWriteReg,
    input  renamePkg::PhysReg                                   dispatchPrevDst,
    output logic                                                dispatchReady,
    output renamePkg::PhysReg                                   dispatchDst,
    output renamePkg::AlIndex                                   dispatchIndex,
    input  logic                                                commit,
    input  renamePkg::LaneCount                                 commitNum,
    input  logic                                                recover,
    input  renamePkg::AlIndex                                   flushIndex,
    output renamePkg::ReleaseLane [renamePkg::commitWidth-1:0]  releaseLanes,
    output renamePkg::LaneCount                                 flushNum,
    output logic                                                inRecovery,
    output renamePkg::AlCount                                   alCount,
    output renamePkg::FreeCount                                 freeCount
);
    import renamePkg::*;

    logic alFull;
    logic freeEmpty;
    logic dispatchFire;
    AlEntry pushEntry;

    AlEntry [commitWidth-1:0] alHeadEntries;
    AlEntry [commitWidth-1:0] alTailEntries;
    AlCount recoveryEntryNum;
    LaneCount popHeadNum;
    LaneCount popTailNum;

    // A register is needed only when the op writes one.
    assign dispatchReady = !alFull && !inRecovery && (!dispatchWriteReg || !freeEmpty);
    assign dispatchFire  = dispatchValid && dispatchReady;

    assign pushEntry.writeReg    = dispatchWriteReg;
    assign pushEntry.physDst     = dispatchDst;
    assign pushEntry.physPrevDst = dispatchPrevDst;

    activeList activeListInst (
        .clk              (clk),
        .rstN             (rstN),
        .pushValid        (dispatchFire),
        .pushEntry        (pushEntry),
        .pushIndex        (dispatchIndex),
        .full             (alFull),
        .popHeadNum       (popHeadNum),
        .popTailNum       (popTailNum),
        .flushIndex       (flushIndex),
        .headEntries      (alHeadEntries),
        .tailEntries      (alTailEntries),
        .recoveryEntryNum (recoveryEntryNum),
        .count            (alCount)
    );

    renameCommitter committerInst (
        .clk              (clk),
        .rstN             (rstN),
        .commit           (commit),
        .commitNum        (commitNum),
        .recover          (recover),
        .headEntries      (alHeadEntries),
        .tailEntries      (alTailEntries),
        .recoveryEntryNum (recoveryEntryNum),
        .popHeadNum       (popHeadNum),
        .popTailNum       (popTailNum),
        .releaseLanes     (releaseLanes),
        .flushNum         (flushNum),
        .inRecovery       (inRecovery)
    );

    freeList freeListInst (
        .clk          (clk),
        .rstN         (rstN),
        .allocate     (dispatchFire && dispatchWriteReg),
        .allocReg     (dispatchDst),
        .empty        (freeEmpty),
        .releaseLanes (releaseLanes),
        .count        (freeCount)
    );

endmodule

`default_nettype wire

//--- bench/renameBench.sv
// Rename unit testbench.
// Reads one operation per line from the cases file, drives the rename
// unit and compares dispatch, release and occupancy results.

`default_nettype none
`timescale 1ns/100ps

module renameBench;
    import renamePkg::*;

    logic clk;
    logic rstN;
    logic dispatchValid;
    logic dispatchWriteReg;
    PhysReg dispatchPrevDst;
    logic dispatchReady;
    PhysReg dispatchDst;
    AlIndex dispatchIndex;
    logic commit;
    LaneCount commitNum;
    logic recover;
    AlIndex flushIndex;
    ReleaseLane [commitWidth-1:0] releaseLanes;
    LaneCount flushNum;
    logic inRecovery;
    AlCount alCount;
    FreeCount freeCount;

    int errorCount = 0;
    int checkCount = 0;

    // Expected active list tail and occupancy after the operations so far.
    int modelTail = 0;
    int modelCount = 0;

    renameUnit uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // Register number of a valid lane, 0 when the lane is empty.
    function automatic logic [31:0] laneValue(input ReleaseLane lane);
        if (lane.valid) begin
            return 32'(lane.physReg);
        end
        return 32'd0;
    endfunction

    task automatic driveIdle();
        dispatchValid <= 1'b0;
        commit        <= 1'b0;
        recover       <= 1'b0;
    endtask

    // Consecutive dispatches. Destinations and previous destinations count up.
    // Each accepted op takes the next active list position.
    task automatic dispatchOps(input int num, input int writeReg, input int prevDst,
                               input int ready, input int firstDst);
        for (int i = 0; i < num; i++) begin
            @(posedge clk);
            driveIdle();
            dispatchValid    <= 1'b1;
            dispatchWriteReg <= writeReg[0];
            dispatchPrevDst  <= PhysReg'(prevDst + i);
            @(negedge clk);
            checkValue("dispatchReady", 32'(dispatchReady), 32'(ready));
            checkValue("dispatchDst", 32'(dispatchDst), 32'(firstDst + i));
            checkValue("dispatchIndex", 32'(dispatchIndex), 32'(modelTail));
            if (ready != 0) begin
                modelTail  = (modelTail + 1) % activeListDepth;
                modelCount = modelCount + 1;
            end
        end
    endtask

    task automatic commitOps(input int num, input int lane0, input int lane1);
        modelCount = modelCount - num;
        @(posedge clk);
        driveIdle();
        commit    <= 1'b1;
        commitNum <= LaneCount'(num);
        @(posedge clk);
        commit <= 1'b0;
        @(negedge clk);
        checkValue("releaseLanes[0]", laneValue(releaseLanes[0]), 32'(lane0));
        checkValue("releaseLanes[1]", laneValue(releaseLanes[1]), 32'(lane1));
    endtask

    task automatic recoverOps(input int args[10], input int caseNum);
        int released[$];
        int cycles;
        int squashNum;
        int remaining;
        int expFlush;
        // Squashed ops run from flushIndex to the tail, all of them on a full list.
        squashNum = ((modelTail - args[0]) % activeListDepth + activeListDepth)
                    % activeListDepth;
        if (squashNum == 0 && modelCount == activeListDepth) begin
            squashNum = activeListDepth;
        end
        remaining  = squashNum;
        modelTail  = args[0];
        modelCount = modelCount - squashNum;
        @(posedge clk);
        driveIdle();
        recover    <= 1'b1;
        flushIndex <= AlIndex'(args[0]);
        @(posedge clk);
        recover          <= 1'b0;
        // A dispatch attempt during the walk must be dropped.
        dispatchValid    <= 1'b1;
        dispatchWriteReg <= 1'b1;
        @(negedge clk);
        checkValue("inRecovery", 32'(inRecovery), 32'd1);
        checkValue("dispatchReady", 32'(dispatchReady), 32'd0);
        checkValue("flushNum", 32'(flushNum), 32'd0);
        @(posedge clk);
        dispatchValid <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            expFlush = (remaining > commitWidth) ? commitWidth : remaining;
            checkValue("flushNum", 32'(flushNum), 32'(expFlush));
            remaining = remaining - expFlush;
            for (int i = 0; i < commitWidth; i++) begin
                if (releaseLanes[i].valid) begin
                    released.push_back(int'(releaseLanes[i].physReg));
                end
            end
        end while (inRecovery && cycles < 50);
        if (inRecovery) begin
            errorCount++;
            $display("case %0d: inRecovery did not fall within 50 cycles", caseNum);
        end else begin
            checkValue("recovery cycles", 32'(cycles), 32'(2 + (squashNum + 1) / 2));
        end
        checkValue("release count", 32'(released.size()), 32'(args[1]));
        for (int i = 0; i < released.size() && i < 8; i++) begin
            checkValue("released physReg", 32'(released[i]), 32'(args[i + 2]));
        end
    endtask

    task automatic checkCounts(input int expAlCount, input int expFreeCount);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkValue("alCount", 32'(alCount), 32'(expAlCount));
        checkValue("freeCount", 32'(freeCount), 32'(expFreeCount));
        checkValue("inRecovery", 32'(inRecovery), 32'd0);
        checkValue("releaseLanes[0]", laneValue(releaseLanes[0]), 32'd0);
        checkValue("releaseLanes[1]", laneValue(releaseLanes[1]), 32'd0);
    endtask

    task automatic idleCycles(input int num);
        repeat (num) begin
            @(posedge clk);
            driveIdle();
        end
    endtask

    task automatic runCase(input string op, input int args[10], input int caseNum);
        case (op)
            "D": dispatchOps(args[0], args[1], args[2], args[3], args[4]);
            "C": commitOps(args[0], args[1], args[2]);
            "R": recoverOps(args, caseNum);
            "W": idleCycles(args[0]);
            "K": checkCounts(args[0], args[1]);
            default: begin
                errorCount++;
                $display("case %0d: unknown operation %s", caseNum, op);
            end
        endcase
    endtask

    initial begin
        int fd;
        int caseNum;
        int errorsBefore;
        int fields;
        int args[10];
        string line;
        string op;
        rstN             = 1'b0;
        dispatchValid    = 1'b0;
        dispatchWriteReg = 1'b0;
        dispatchPrevDst  = '0;
        commit           = 1'b0;
        commitNum        = '0;
        recover          = 1'b0;
        flushIndex       = '0;
        caseNum          = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        fd = $fopen("bench/renameCases.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open bench/renameCases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                fields = $fgets(line, fd);
                // Skip blank and comment lines.
                if (fields > 0 && line.len() > 1 && line[0] != "#") begin
                    for (int i = 0; i < 10; i++) begin
                        args[i] = 0;
                    end
                    fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", op,
                                     args[0], args[1], args[2], args[3], args[4],
                                     args[5], args[6], args[7], args[8], args[9]);
                    caseNum++;
                    errorsBefore = errorCount;
                    runCase(op, args, caseNum);
                    $display("case %0d %s %s", caseNum, op,
                             (errorCount == errorsBefore) ? "ok" : "with errors");
                end
            end
            $fclose(fd);
        end
        $display("%0d cases, %0d checks, %0d errors", caseNum, checkCount, errorCount);
        if (errorCount == 0 && caseNum > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/renameCases.txt
# D count writeReg prevDst ready firstDst | C num lane0 lane1 (0 = none) | K alCount freeCount
# R flushIndex releaseCount then released regs youngest first | W idle cycles
W 2
K 0 24
D 1 1 1 1 8
D 1 1 2 1 9
D 1 0 0 1 10
D 1 1 3 1 10
K 4 21
C 2 1 2
K 2 23
C 2 0 3
C 0 0 0
K 0 24
D 3 1 4 1 11
D 1 0 0 1 14
D 1 1 7 1 14
K 5 20
C 1 4 0
K 4 21
R 6 2 14 13 0 0 0 0 0 0
K 1 23
D 15 1 16 1 15
D 1 1 9 0 30
K 16 8
R 13 8 29 28 27 26 25 24 23 22
K 8 16
D 2 1 1 1 30
D 4 1 3 1 1
D 1 1 9 1 14
D 1 1 10 1 13
D 1 1 11 0 29
K 16 8

//--- project.f
design/renamePkg.sv
design/activeList.sv
design/renameCommitter.sv
design/freeList.sv
design/renameUnit.sv
bench/renameBench.sv

//--- run.sh
#!/bin/sh
# Builds the rename unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --top-module renameBench -f project.f -o renameSim
./obj_dir/renameSim > sim.log
cat sim.log

if grep -q -F "*** FAILED ***" sim.log; then
    exit 1
fi
